//--- src/lh_pp_pkg.sv
`default_nettype none

package lh_pp_pkg;

	// ========================================
	// table geometry
	// ========================================

	// log2 of forwarding table size
	localparam int LH_TABLE_NBITS = 4;

	// egress port used on a table miss
	localparam logic [2:0] LH_FLOOD_PORT = 3'd7;

	// ========================================
	// metadata and results
	// ========================================

	// parsed header metadata, 28 bits
	typedef struct packed {
		logic [2:0]  src_port;
		logic [7:0]  dst_key;
		logic [5:0]  flow_id;
		logic [10:0] pkt_len;
	} lh_pp_meta_type;

	// forwarding decision, 22 bits
	typedef struct packed {
		logic [2:0]  egress_port;
		logic        drop;
		logic [5:0]  flow_id;
		logic [10:0] pkt_len;
		logic        hit;
	} lh_pp_result_type;

	// one table slot
	typedef struct packed {
		logic       valid;
		logic [2:0] port;
	} lh_fwd_entry_type;

endpackage

`default_nettype wire

//--- src/sfifo_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sfifo_ctrl #(
	parameter int DEPTH_NBITS = 3,
	parameter int DEPTH = (1 << DEPTH_NBITS)
) (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    rd,
	input  wire                    wr,
	output logic [DEPTH_NBITS:0]   ncount,
	output logic [DEPTH_NBITS:0]   count,
	output logic                   full,
	output logic                   empty,
	output logic                   fullm1,
	output logic                   emptyp1,
	output logic                   emptyp2,
	output logic [DEPTH_NBITS-1:0] rptr,
	output logic [DEPTH_NBITS-1:0] wptr
);

	// ========================================
	// thresholds
	// ========================================

	// last usable slot, pointers wrap here
	localparam logic [DEPTH_NBITS-1:0] LAST_PTR = DEPTH_NBITS'(DEPTH - 1);
	localparam logic [DEPTH_NBITS:0] FULL_CNT = (DEPTH_NBITS + 1)'(DEPTH);
	localparam logic [DEPTH_NBITS:0] FULLM1_CNT = (DEPTH_NBITS + 1)'(DEPTH - 1);

	// circular increment, depth need not be a power of two
	function automatic logic [DEPTH_NBITS-1:0] ptr_inc(input logic [DEPTH_NBITS-1:0] p);
		return (p == LAST_PTR) ? '0 : p + 1'b1;
	endfunction

	// ========================================
	// occupancy
	// ========================================

	// next count, callers qualify rd and wr
	always_comb begin
		ncount = count;
		if (wr && !rd)
			ncount = count + 1'b1;
		else if (rd && !wr)
			ncount = count - 1'b1;
	end

	// pointers, count and registered flags
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rptr    <= '0;
			wptr    <= '0;
			count   <= '0;
			full    <= 1'b0;
			empty   <= 1'b1;
			fullm1  <= (FULLM1_CNT == '0);
			emptyp1 <= 1'b0;
			emptyp2 <= 1'b0;
		end else begin
			if (rd)
				rptr <= ptr_inc(rptr);
			if (wr)
				wptr <= ptr_inc(wptr);
			count <= ncount;
			// flags from next count, so no comb path to users
			full    <= (ncount == FULL_CNT);
			empty   <= (ncount == '0);
			fullm1  <= (ncount == FULLM1_CNT);
			emptyp1 <= (ncount == (DEPTH_NBITS + 1)'(1));
			emptyp2 <= (ncount == (DEPTH_NBITS + 1)'(2));
		end
	end

endmodule

`default_nettype wire

//--- src/sfifo_reg_out.sv
`timescale 1ns/1ps
`default_nettype none

module sfifo_reg_out
	import lh_pp_pkg::*;
#(
	parameter int DEPTH_NBITS = 3,
	parameter type payload_type = lh_pp_meta_type
) (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  wr,
	input  wire                  rd,
	input  wire payload_type     din,
	output payload_type          dout,
	output logic [DEPTH_NBITS:0] ncount,
	output logic [DEPTH_NBITS:0] count,
	output logic                 full,
	output logic                 fullm1,
	output logic                 empty,
	output logic                 emptyp2
);

	// head register holds one word, array holds the rest
	localparam int DEPTH = 1 << DEPTH_NBITS;
	localparam int ARR_DEPTH = DEPTH - 1;

	payload_type mem [ARR_DEPTH];
	payload_type arr_dout;

	logic                   arr_rd;
	logic                   arr_wr;
	logic [DEPTH_NBITS:0]   arr_ncount;
	logic                   arr_full;
	logic                   arr_empty;
	logic                   arr_fullm1;
	logic                   arr_emptyp1;
	logic [DEPTH_NBITS-1:0] arr_rptr;
	logic [DEPTH_NBITS-1:0] arr_wptr;
	logic                   nempty;

	// ========================================
	// head word control
	// ========================================

	// head goes empty only on a read with nothing behind it
	assign nempty = (wr == rd) ? empty : (!wr && rd && arr_empty);

	// array only moves once the head is occupied
	assign arr_rd = rd && !arr_empty;
	assign arr_wr = wr && !(empty || (arr_empty && rd));

	// total occupancy is array plus head
	assign ncount = arr_ncount + {{DEPTH_NBITS{1'b0}}, !nempty};

	// array full implies head full
	assign full    = arr_full;
	assign fullm1  = arr_fullm1;
	assign emptyp2 = arr_emptyp1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			empty <= 1'b1;
			count <= '0;
		end else begin
			empty <= nempty;
			count <= ncount;
		end
	end

	// load from array head, or bypass din when array is empty
	always_ff @(posedge clk) begin
		if ((wr && empty) || rd)
			dout <= (rd && !arr_empty) ? arr_dout : din;
	end

	// ========================================
	// storage array
	// ========================================

	sfifo_ctrl #(
		.DEPTH_NBITS (DEPTH_NBITS),
		.DEPTH       (ARR_DEPTH)
	) u_sfifo_ctrl (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd      (arr_rd),
		.wr      (arr_wr),
		.ncount  (arr_ncount),
		.count   (),
		.full    (arr_full),
		.empty   (arr_empty),
		.fullm1  (arr_fullm1),
		.emptyp1 (arr_emptyp1),
		.emptyp2 (),
		.rptr    (arr_rptr),
		.wptr    (arr_wptr)
	);

	assign arr_dout = mem[arr_rptr];

	always_ff @(posedge clk) begin
		if (arr_wr)
			mem[arr_wptr] <= din;
	end

endmodule

`default_nettype wire

//--- src/lh_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module lh_lookup
	import lh_pp_pkg::*;
#(
	parameter int DEPTH_NBITS = 2
) (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      in_empty,
	input  wire lh_pp_meta_type      in_dout,
	input  wire [DEPTH_NBITS:0]      out_count,
	input  wire                      cfg_wr,
	input  wire [LH_TABLE_NBITS-1:0] cfg_addr,
	input  wire lh_fwd_entry_type    cfg_entry,
	output logic                     fifo_rd,
	output logic                     res_wr,
	output lh_pp_result_type         res_data
);

	localparam int TABLE_SIZE = 1 << LH_TABLE_NBITS;
	// output fifo capacity, one bit wider than out_count for the sum
	localparam logic [DEPTH_NBITS+1:0] OUT_DEPTH = (DEPTH_NBITS + 2)'(1 << DEPTH_NBITS);

	lh_fwd_entry_type          fwd_table [TABLE_SIZE];
	logic [LH_TABLE_NBITS-1:0] rd_idx;
	logic [DEPTH_NBITS+1:0]    credit_used;
	logic                      s1_valid;
	lh_pp_meta_type            s1_meta;
	lh_fwd_entry_type          s1_entry;
	lh_pp_result_type          s2_result;

	// ========================================
	// forwarding table
	// ========================================

	// sw writes one slot per cycle, all invalid after reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < TABLE_SIZE; i++)
				fwd_table[i] <= '0;
		end else if (cfg_wr) begin
			fwd_table[cfg_addr] <= cfg_entry;
		end
	end

	// hash index: low key bits xor ingress port
	assign rd_idx = in_dout.dst_key[LH_TABLE_NBITS-1:0] ^ LH_TABLE_NBITS'(in_dout.src_port);

	// ========================================
	// credit and stage 1
	// ========================================

	// queued results plus both stages in flight
	assign credit_used = {1'b0, out_count} + (DEPTH_NBITS + 2)'(s1_valid)
		+ (DEPTH_NBITS + 2)'(res_wr);
	assign fifo_rd = !in_empty && (credit_used < OUT_DEPTH);

	always_ff @(posedge clk) begin
		if (!rst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= fifo_rd;
	end

	// table read sees writes from earlier cycles only
	always_ff @(posedge clk) begin
		if (fifo_rd) begin
			s1_meta  <= in_dout;
			s1_entry <= fwd_table[rd_idx];
		end
	end

	// ========================================
	// stage 2
	// ========================================

	always_comb begin
		s2_result.hit         = s1_entry.valid;
		// miss floods
		s2_result.egress_port = s1_entry.valid ? s1_entry.port : LH_FLOOD_PORT;
		// hairpin back to ingress is dropped
		s2_result.drop        = s1_entry.valid && (s1_entry.port == s1_meta.src_port);
		s2_result.flow_id     = s1_meta.flow_id;
		s2_result.pkt_len     = s1_meta.pkt_len;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			res_wr <= 1'b0;
		else
			res_wr <= s1_valid;
	end

	always_ff @(posedge clk) begin
		if (s1_valid)
			res_data <= s2_result;
	end

endmodule

`default_nettype wire

//--- src/lh_pp_top.sv
`timescale 1ns/1ps
`default_nettype none

module lh_pp_top
	import lh_pp_pkg::*;
#(
	parameter int IN_DEPTH_NBITS = 3,
	parameter int OUT_DEPTH_NBITS = 2
) (
	input  wire                      clk,
	input  wire                      rst_n,
	// parser side
	input  wire                      in_wr,
	input  wire lh_pp_meta_type      in_meta,
	output wire                      in_full,
	output wire                      in_fullm1,
	// table config
	input  wire                      cfg_wr,
	input  wire [LH_TABLE_NBITS-1:0] cfg_addr,
	input  wire lh_fwd_entry_type    cfg_entry,
	// downstream drain
	input  wire                      out_rd,
	output wire                      out_empty,
	output wire lh_pp_result_type    out_result,
	output wire [OUT_DEPTH_NBITS:0]  out_count
);

	wire                   in_empty;
	wire lh_pp_meta_type   in_dout;
	wire                   fifo_rd;
	wire                   res_wr;
	wire lh_pp_result_type res_data;

	// ========================================
	// metadata in
	// ========================================

	sfifo_reg_out #(
		.DEPTH_NBITS  (IN_DEPTH_NBITS),
		.payload_type (lh_pp_meta_type)
	) u_in_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr      (in_wr),
		.rd      (fifo_rd),
		.din     (in_meta),
		.dout    (in_dout),
		.ncount  (),
		.count   (),
		.full    (in_full),
		.fullm1  (in_fullm1),
		.empty   (in_empty),
		.emptyp2 ()
	);

	// lookup sized against the output fifo depth
	lh_lookup #(
		.DEPTH_NBITS (OUT_DEPTH_NBITS)
	) u_lookup (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_empty  (in_empty),
		.in_dout   (in_dout),
		.out_count (out_count),
		.cfg_wr    (cfg_wr),
		.cfg_addr  (cfg_addr),
		.cfg_entry (cfg_entry),
		.fifo_rd   (fifo_rd),
		.res_wr    (res_wr),
		.res_data  (res_data)
	);

	// ========================================
	// results out
	// ========================================

	// never full on write, lookup holds credit
	sfifo_reg_out #(
		.DEPTH_NBITS  (OUT_DEPTH_NBITS),
		.payload_type (lh_pp_result_type)
	) u_out_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr      (res_wr),
		.rd      (out_rd),
		.din     (res_data),
		.dout    (out_result),
		.ncount  (),
		.count   (out_count),
		.full    (),
		.fullm1  (),
		.empty   (out_empty),
		.emptyp2 ()
	);

endmodule

`default_nettype wire

//--- test/lh_pp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sfifo_checker (
	input wire clk,
	input wire rst_n,
	input wire wr,
	input wire rd,
	input wire full,
	input wire empty
);

	// ========================================
	// fifo protocol rules
	// ========================================

	// writer has to respect full
	no_wr_when_full: assert property (@(posedge clk) disable iff (!rst_n) !(wr && full))
		else $error("fifo written while full");

	// reader has to respect empty
	no_rd_when_empty: assert property (@(posedge clk) disable iff (!rst_n) !(rd && empty))
		else $error("fifo read while empty");

	// flags are exclusive
	full_empty_excl: assert property (@(posedge clk) disable iff (!rst_n) !(full && empty))
		else $error("fifo full and empty together");

endmodule

// one checker per fifo instance
bind sfifo_reg_out sfifo_checker u_sfifo_checker (
	.clk   (clk),
	.rst_n (rst_n),
	.wr    (wr),
	.rd    (rd),
	.full  (full),
	.empty (empty)
);

`default_nettype wire

//--- test/lh_pp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lh_pp_tb
	import lh_pp_pkg::*;
();

	localparam int IN_DEPTH_NBITS = 3;
	localparam int OUT_DEPTH_NBITS = 2;
	localparam int IN_DEPTH = 1 << IN_DEPTH_NBITS;
	localparam int OUT_DEPTH = 1 << OUT_DEPTH_NBITS;
	localparam int TABLE_SIZE = 1 << LH_TABLE_NBITS;
	// items per test
	localparam int N_RANDOM = 60;
	localparam int N_DROP = 40;
	localparam int N_FILL = 16;
	localparam int N_MIXED = 80;
	localparam int N_BURST = 30;
	// four table loads, each write counts as an item
	localparam int PLANNED = N_RANDOM + N_DROP + N_FILL + N_MIXED + 2 * N_BURST + 4 * TABLE_SIZE;
	localparam int CYCLE_LIMIT = 20 * PLANNED + 200;

	logic                      clk = 1'b0;
	logic                      rst_n;
	logic                      in_wr;
	lh_pp_meta_type            in_meta;
	logic                      in_full;
	logic                      in_fullm1;
	logic                      cfg_wr;
	logic [LH_TABLE_NBITS-1:0] cfg_addr;
	lh_fwd_entry_type          cfg_entry;
	logic                      out_rd;
	logic                      out_empty;
	lh_pp_result_type          out_result;
	logic [OUT_DEPTH_NBITS:0]  out_count;

	// model state
	integer                    seed = 32'h8733_280b;
	lh_fwd_entry_type          model_table [TABLE_SIZE];
	lh_pp_result_type          exp_q [$];
	int                        cycles;
	int                        checks;
	int                        errors;
	int                        err_start;
	int                        sent;
	int                        target;
	int                        wr_pct;
	int                        rd_pct;
	int                        meta_mode;
	int                        written;
	int                        pulled;
	int                        consumed;
	int                        drops;
	int                        keeps;
	int                        max_count;
	logic                      saw_full;
	logic                      cfg_req;
	logic [LH_TABLE_NBITS-1:0] cfg_req_addr;
	lh_fwd_entry_type          cfg_req_entry;

	always #10 clk = ~clk;

	// stop a stuck run once the cycle budget is spent
	initial begin
		wait (cycles > CYCLE_LIMIT);
		$display("timeout after %0d cycles, %0d results still outstanding",
			CYCLE_LIMIT, exp_q.size());
		$display("*** FAILED ***");
		$finish;
	end

	lh_pp_top #(
		.IN_DEPTH_NBITS  (IN_DEPTH_NBITS),
		.OUT_DEPTH_NBITS (OUT_DEPTH_NBITS)
	) UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_wr      (in_wr),
		.in_meta    (in_meta),
		.in_full    (in_full),
		.in_fullm1  (in_fullm1),
		.cfg_wr     (cfg_wr),
		.cfg_addr   (cfg_addr),
		.cfg_entry  (cfg_entry),
		.out_rd     (out_rd),
		.out_empty  (out_empty),
		.out_result (out_result),
		.out_count  (out_count)
	);

	// ========================================
	// reference model
	// ========================================

	// forwarding rule applied to the model table
	function automatic lh_pp_result_type expect_result(input lh_pp_meta_type m);
		lh_pp_result_type r;
		lh_fwd_entry_type e;
		e = model_table[m.dst_key[LH_TABLE_NBITS-1:0] ^ LH_TABLE_NBITS'(m.src_port)];
		r.hit = e.valid;
		// miss goes to flood port 7
		r.egress_port = e.valid ? e.port : 3'd7;
		r.drop = e.valid && (e.port == m.src_port);
		r.flow_id = m.flow_id;
		r.pkt_len = m.pkt_len;
		return r;
	endfunction

	function automatic logic roll(input int pct);
		logic [31:0] r;
		r = $random(seed);
		return (r % 100) < pct;
	endfunction

	function automatic lh_pp_meta_type make_meta();
		lh_pp_meta_type m;
		lh_fwd_entry_type e;
		logic [LH_TABLE_NBITS-1:0] idx;
		logic [31:0] r;
		r = $random(seed);
		m = r[27:0];
		if (meta_mode == 1) begin
			// aim at a chosen slot, half the time from its own port
			r = $random(seed);
			idx = r[LH_TABLE_NBITS-1:0];
			e = model_table[idx];
			r = $random(seed);
			if (r[0])
				m.src_port = e.port;
			else
				m.src_port = e.port + 3'(r[31:8] % 7 + 1);
			m.dst_key[LH_TABLE_NBITS-1:0] = idx ^ LH_TABLE_NBITS'(m.src_port);
		end
		return m;
	endfunction

	task automatic flag_mismatch(input string msg);
		errors++;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endtask

	// ========================================
	// one clock: check, then drive
	// ========================================

	task automatic step_cycle();
		lh_pp_result_type exp;
		lh_pp_meta_type m;
		logic wr_ok;
		logic rd_ok;
		int in_level;
		@(posedge clk);
		cycles++;
		if (in_full)
			saw_full = 1'b1;
		if (out_count > max_count)
			max_count = out_count;
		checks++;
		if (out_count > OUT_DEPTH)
			flag_mismatch($sformatf("out_count %0d above depth %0d", out_count, OUT_DEPTH));
		// input fifo level from writes and lookup pops so far
		in_level = written - pulled;
		checks++;
		if (in_full !== (in_level == IN_DEPTH))
			flag_mismatch($sformatf("in_full %b at input level %0d", in_full, in_level));
		if (in_fullm1 !== (in_level == IN_DEPTH - 1))
			flag_mismatch($sformatf("in_fullm1 %b at input level %0d", in_fullm1, in_level));
		// lookup idle, so every pulled item has landed
		if (!UUT.u_lookup.s1_valid && !UUT.res_wr) begin
			checks++;
			if (out_count != pulled - consumed)
				flag_mismatch($sformatf("out_count %0d, expected %0d",
					out_count, pulled - consumed));
			if (out_empty !== (pulled == consumed))
				flag_mismatch($sformatf("out_empty %b with %0d results queued",
					out_empty, pulled - consumed));
		end
		if (out_rd) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("extra result read at %0t ns with nothing expected", $time);
			end else begin
				exp = exp_q.pop_front();
				checks++;
				if (out_result !== exp)
					flag_mismatch($sformatf("result %h, expected %h", out_result, exp));
				if (out_result.drop)
					drops++;
				else
					keeps++;
			end
			consumed++;
		end
		if (UUT.fifo_rd)
			pulled++;
		if (in_wr)
			written++;
		// stays legal even if a write and nothing else lands at this edge
		wr_ok = !in_full && !(in_wr && in_fullm1);
		if (sent < target && wr_ok && roll(wr_pct)) begin
			m = make_meta();
			exp_q.push_back(expect_result(m));
			in_wr <= 1'b1;
			in_meta <= m;
			sent++;
		end else begin
			in_wr <= 1'b0;
		end
		// read only if a word survives this edge
		rd_ok = (int'(out_count) - int'(out_rd)) >= 1;
		out_rd <= rd_ok && roll(rd_pct);
		cfg_wr <= cfg_req;
		cfg_addr <= cfg_req_addr;
		cfg_entry <= cfg_req_entry;
	endtask

	task automatic write_entry(input logic [LH_TABLE_NBITS-1:0] addr,
		input lh_fwd_entry_type e);
		cfg_req = 1'b1;
		cfg_req_addr = addr;
		cfg_req_entry = e;
		model_table[addr] = e;
		step_cycle();
		cfg_req = 1'b0;
	endtask

	// mode 0 random, 1 all valid, 2 all valid with every port changed
	task automatic load_table(input int mode);
		lh_fwd_entry_type e;
		logic [31:0] r;
		for (int i = 0; i < TABLE_SIZE; i++) begin
			r = $random(seed);
			e = r[3:0];
			if (mode != 0)
				e.valid = 1'b1;
			if (mode == 2)
				e.port = model_table[i].port ^ 3'd5;
			write_entry(LH_TABLE_NBITS'(i), e);
		end
	endtask

	task automatic run_burst(input int n, input int wpct, input int rpct);
		target = sent + n;
		wr_pct = wpct;
		rd_pct = rpct;
		while (sent < target || exp_q.size() != 0)
			step_cycle();
	endtask

	// idle cycles with reads enabled catch duplicates
	task automatic settle(input int n);
		rd_pct = 100;
		for (int i = 0; i < n; i++)
			step_cycle();
	endtask

	task automatic end_test(input string name);
		if (errors == err_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_start);
		err_start = errors;
	endtask

	// ========================================
	// test sequence
	// ========================================

	initial begin
		rst_n = 1'b0;
		in_wr = 1'b0;
		in_meta = '0;
		cfg_wr = 1'b0;
		cfg_addr = '0;
		cfg_entry = '0;
		out_rd = 1'b0;
		cfg_req = 1'b0;
		cfg_req_addr = '0;
		cfg_req_entry = '0;
		cycles = 0;
		checks = 0;
		errors = 0;
		err_start = 0;
		sent = 0;
		target = 0;
		wr_pct = 0;
		rd_pct = 0;
		meta_mode = 0;
		written = 0;
		pulled = 0;
		consumed = 0;
		drops = 0;
		keeps = 0;
		max_count = 0;
		saw_full = 1'b0;
		for (int i = 0; i < TABLE_SIZE; i++)
			model_table[i] = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// reset values, nothing driven yet
		@(posedge clk);
		checks++;
		if (!out_empty)
			flag_mismatch("out_empty low after reset");
		if (in_full)
			flag_mismatch("in_full high after reset");
		if (out_count != 0)
			flag_mismatch($sformatf("out_count %0d after reset", out_count));
		end_test("1 reset state");

		load_table(0);
		run_burst(N_RANDOM, 70, 100);
		settle(8);
		end_test("2 random lookups");

		// all slots valid, half the items hairpin
		load_table(1);
		meta_mode = 1;
		drops = 0;
		keeps = 0;
		run_burst(N_DROP, 70, 100);
		settle(8);
		if (drops == 0 || keeps == 0) begin
			errors++;
			$display("drop rule not covered: %0d dropped, %0d kept", drops, keeps);
		end
		end_test("3 drop rule");

		// fill everything with the output stalled
		meta_mode = 0;
		saw_full = 1'b0;
		max_count = 0;
		target = sent + N_FILL;
		wr_pct = 100;
		rd_pct = 0;
		for (int i = 0; i < 100 && !saw_full; i++)
			step_cycle();
		target = sent;
		if (!saw_full) begin
			errors++;
			$display("in_full never rose while the output was stalled");
		end
		if (max_count != OUT_DEPTH) begin
			errors++;
			$display("output fifo peaked at %0d words, depth is %0d", max_count, OUT_DEPTH);
		end
		run_burst(0, 0, 100);
		settle(8);
		end_test("4 back-pressure");

		run_burst(N_MIXED, 50, 40);
		settle(8);
		end_test("5 random flow");

		// second table differs in every slot
		load_table(0);
		run_burst(N_BURST, 70, 100);
		load_table(2);
		run_burst(N_BURST, 70, 100);
		settle(8);
		end_test("6 table reprogram");

		$display("checks %0d, errors %0d, items %0d, cycles %0d", checks, errors, sent, cycles);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- lh_pp.f
src/lh_pp_pkg.sv
src/sfifo_ctrl.sv
src/sfifo_reg_out.sv
src/lh_lookup.sv
src/lh_pp_top.sv
test/lh_pp_checker.sv
test/lh_pp_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = lh_pp_tb
FILELIST = lh_pp.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = *** FAILED ***

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
